//--- design/lease_cache_pkg.sv
package lease_cache_pkg;

	// cache geometry
	localparam int N_LINES       = 8;
	localparam int BW_LINE       = 3;
	localparam int BW_BLOCK      = 2;                  // 4 words per block
	localparam int BW_ADDR       = 12;                 // word address
	localparam int BW_TAG        = BW_ADDR - BW_BLOCK;
	localparam int BW_DATA       = 32;
	localparam int BW_DMEM       = BW_LINE + BW_BLOCK; // data memory word index
	localparam int DMEM_WORDS    = N_LINES << BW_BLOCK;

	// lease settings
	localparam int BW_LEASE      = 8;
	localparam int LLT_ENTRIES   = 8;
	localparam int BW_LLT        = 3;
	localparam logic [BW_LEASE-1:0] DEFAULT_LEASE = 8'd4;

	typedef struct packed {
		logic                rw;    // 1 = store
		logic [BW_TAG-1:0]   tag;
		logic [BW_BLOCK-1:0] word;
		logic [BW_DATA-1:0]  data;
	} core_req_t;

	// broadcast to every line each cycle
	typedef struct packed {
		logic                age;       // all lines count down
		logic                renew;     // target loads lease
		logic                fill;      // target takes new tag
		logic                set_dirty;
		logic                clean;
		logic [BW_LINE-1:0]  target;
		logic [BW_TAG-1:0]   tag;
		logic [BW_LEASE-1:0] lease;
	} line_cmd_t;

	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic              match;
		logic              expired; // lease ran out
		logic [BW_TAG-1:0] tag;
	} line_status_t;

	typedef struct packed {
		logic               hit;
		logic [BW_LINE-1:0] hit_line;
		logic [BW_LINE-1:0] victim_line;
		logic               victim_dirty;
		logic [BW_TAG-1:0]  victim_tag;
		logic               forced; // no free or expired line found
	} line_sel_t;

	typedef struct packed {
		logic               req;   // one-cycle strobe
		logic               block; // 4-word read
		logic               rw;
		logic [BW_ADDR-1:0] addr;
		logic [BW_DATA-1:0] wdata;
	} mem_cmd_t;

endpackage

//--- design/lease_table.sv
`timescale 1ns/1ns

module lease_table (
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  logic                                llt_wren_i,
	input  logic [lease_cache_pkg::BW_LLT-1:0]   llt_idx_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]   llt_tag_i,
	input  logic [lease_cache_pkg::BW_LEASE-1:0] llt_lease_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]   search_tag_i,
	output logic [lease_cache_pkg::BW_LEASE-1:0] lease_o
);
	import lease_cache_pkg::*;

	logic [LLT_ENTRIES-1:0] ent_valid_q;
	logic [BW_TAG-1:0]      ent_tag_q   [LLT_ENTRIES];
	logic [BW_LEASE-1:0]    ent_lease_q [LLT_ENTRIES];
	logic [LLT_ENTRIES-1:0] match_vec;

	// table programming
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			ent_valid_q <= '0; // table empty after reset
		end else if (llt_wren_i) begin
			ent_valid_q[llt_idx_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (llt_wren_i) begin
			ent_tag_q[llt_idx_i]   <= llt_tag_i;
			ent_lease_q[llt_idx_i] <= llt_lease_i;
		end
	end

	// search
	// ------------------------------
	always_comb begin
		lease_o   = DEFAULT_LEASE; // unlisted tags
		match_vec = '0;
		for (int i = 0; i < LLT_ENTRIES; i++) begin
			if (ent_valid_q[i] && ent_tag_q[i] == search_tag_i) begin
				match_vec[i] = 1'b1;
				lease_o      = ent_lease_q[i];
			end
		end
	end

	// one tag per table
	a_llt_unique: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match_vec));

endmodule

//--- design/lease_line.sv
`timescale 1ns/1ns

module lease_line #(
	parameter int LINE_INDEX = 0
) (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  lease_cache_pkg::line_cmd_t    cmd_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0] probe_tag_i,
	output lease_cache_pkg::line_status_t status_o
);
	import lease_cache_pkg::*;

	logic                valid_q;
	logic                dirty_q;
	logic [BW_TAG-1:0]   tag_q;
	logic [BW_LEASE-1:0] lease_q;
	logic                targeted;

	assign targeted = (cmd_i.target == BW_LINE'(LINE_INDEX));

	// line state
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= 1'b0;
			dirty_q <= 1'b0;
			lease_q <= '0;
		end else begin
			// renew wins over aging
			if (targeted && cmd_i.renew) begin
				lease_q <= cmd_i.lease;
			end else if (cmd_i.age && lease_q != '0) begin
				lease_q <= lease_q - 1'b1;
			end

			if (targeted && cmd_i.fill) begin
				valid_q <= 1'b1;
				dirty_q <= 1'b0; // fresh block is clean
			end else if (targeted && cmd_i.set_dirty) begin
				dirty_q <= 1'b1;
			end else if (targeted && cmd_i.clean) begin
				dirty_q <= 1'b0; // after writeback
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (targeted && cmd_i.fill) begin
			tag_q <= cmd_i.tag;
		end
	end

	// status report
	always_comb begin
		status_o.valid   = valid_q;
		status_o.dirty   = dirty_q;
		status_o.match   = valid_q && (tag_q == probe_tag_i);
		status_o.expired = (lease_q == '0);
		status_o.tag     = tag_q;
	end

	// controller must not mark a free line
	a_dirty_valid: assert property (@(posedge clock_i) disable iff (!resetn_i)
		dirty_q |-> valid_q);

endmodule

//--- design/line_select.sv
`timescale 1ns/1ns

module line_select (
	input  logic                          clock_i,
	input  logic                          resetn_i,
	input  lease_cache_pkg::line_status_t status_i [lease_cache_pkg::N_LINES],
	input  logic                          evict_step_i,
	output lease_cache_pkg::line_sel_t    sel_o
);
	import lease_cache_pkg::*;

	logic [BW_LINE-1:0] rr_ptr_q;
	logic [N_LINES-1:0] match_vec;
	logic               hit;
	logic [BW_LINE-1:0] hit_line;
	logic               found;
	logic [BW_LINE-1:0] victim;

	// round-robin fallback pointer
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			rr_ptr_q <= '0;
		end else if (evict_step_i) begin
			rr_ptr_q <= rr_ptr_q + 1'b1; // wraps at N_LINES
		end
	end

	// hit and victim search
	// ------------------------------
	always_comb begin
		match_vec = '0;
		hit       = 1'b0;
		hit_line  = '0;
		found     = 1'b0;
		victim    = rr_ptr_q;
		for (int i = 0; i < N_LINES; i++) begin
			match_vec[i] = status_i[i].match;
			if (status_i[i].match) begin
				hit      = 1'b1;
				hit_line = BW_LINE'(i);
			end
			// lowest free or expired line
			if (!found && (!status_i[i].valid || status_i[i].expired)) begin
				found  = 1'b1;
				victim = BW_LINE'(i);
			end
		end
	end

	always_comb begin
		sel_o.hit          = hit;
		sel_o.hit_line     = hit_line;
		sel_o.victim_line  = victim;
		sel_o.victim_dirty = status_i[victim].dirty;
		sel_o.victim_tag   = status_i[victim].tag;
		sel_o.forced       = !found;
	end

	// a tag lives in one line only
	a_single_hit: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match_vec));

endmodule

//--- design/cache_data_mem.sv
`timescale 1ns/1ns

module cache_data_mem (
	input  logic                                clock_i,
	input  logic                                we_i,
	input  logic [lease_cache_pkg::BW_DMEM-1:0] waddr_i,
	input  logic [lease_cache_pkg::BW_DATA-1:0] wdata_i,
	input  logic [lease_cache_pkg::BW_DMEM-1:0] raddr_i,
	output logic [lease_cache_pkg::BW_DATA-1:0] rdata_o
);
	import lease_cache_pkg::*;

	// line-major word storage
	logic [BW_DATA-1:0] mem_q [DMEM_WORDS];

	// write port
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (we_i) begin
			mem_q[waddr_i] <= wdata_i;
		end
	end

	// one-cycle read port
	always_ff @(posedge clock_i) begin
		rdata_o <= mem_q[raddr_i]; // old data on same-address write
	end

endmodule

//--- design/lease_cache_ctrl.sv
`timescale 1ns/1ns

module lease_cache_ctrl (
	input  logic                                 clock_i,
	input  logic                                 resetn_i,
	// core side
	input  logic                                 core_req_i,
	input  logic                                 core_rw_i,
	input  logic [lease_cache_pkg::BW_ADDR-1:0]  core_addr_i,
	input  logic [lease_cache_pkg::BW_DATA-1:0]  core_wdata_i,
	output logic                                 core_done_o,
	output logic                                 core_hit_o,
	output logic [lease_cache_pkg::BW_DATA-1:0]  core_rdata_o,
	// lease table and lines
	input  logic [lease_cache_pkg::BW_LEASE-1:0] lease_i,
	output lease_cache_pkg::core_req_t           req_o,
	input  lease_cache_pkg::line_sel_t           sel_i,
	output lease_cache_pkg::line_cmd_t           line_cmd_o,
	output logic                                 evict_step_o,
	// data memory
	output logic                                 dm_we_o,
	output logic [lease_cache_pkg::BW_DMEM-1:0]  dm_waddr_o,
	output logic [lease_cache_pkg::BW_DATA-1:0]  dm_wdata_o,
	output logic [lease_cache_pkg::BW_DMEM-1:0]  dm_raddr_o,
	input  logic [lease_cache_pkg::BW_DATA-1:0]  rdata_i,
	// main memory
	output lease_cache_pkg::mem_cmd_t            mem_cmd_o,
	input  logic                                 mem_ready_i,
	input  logic                                 mem_rvalid_i,
	input  logic [lease_cache_pkg::BW_DATA-1:0]  mem_rdata_i,
	// performance pulses
	output logic                                 flag_miss_o,
	output logic                                 flag_writeback_o,
	output logic                                 flag_rand_evict_o
);
	import lease_cache_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE, ST_LOOKUP, ST_HIT_READ, ST_WRITEBACK,
		ST_FILL_REQ, ST_FILL, ST_BYP_REQ, ST_BYP_WAIT
	} state_t;

	state_t              state_q;
	logic                retry_q;    // lookup after a fill
	logic                miss_q;     // request missed at first lookup
	logic                byp_done_q;
	logic [BW_BLOCK-1:0] cnt_q;      // word counter
	logic                flag_miss_q;
	logic                flag_wb_q;
	logic                flag_rand_q;
	core_req_t           req_q;
	logic [BW_LINE-1:0]  victim_q;
	logic [BW_TAG-1:0]   victim_tag_q;
	logic [BW_LEASE-1:0] lease_q;
	logic [BW_DATA-1:0]  byp_data_q;
	logic                first_miss;
	logic [BW_BLOCK-1:0] wb_word;

	assign req_o             = req_q;
	assign core_done_o       = (state_q == ST_HIT_READ) || byp_done_q;
	assign core_hit_o        = (state_q == ST_HIT_READ) && !miss_q;
	assign core_rdata_o      = byp_done_q ? byp_data_q : rdata_i;
	assign flag_miss_o       = flag_miss_q;
	assign flag_writeback_o  = flag_wb_q;
	assign flag_rand_evict_o = flag_rand_q;
	assign first_miss        = (state_q == ST_LOOKUP) && !sel_i.hit && (lease_i != '0);
	assign wb_word           = cnt_q + BW_BLOCK'(mem_ready_i); // read one word ahead

	// sequencer
	// ------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q     <= ST_IDLE;
			retry_q     <= 1'b0;
			miss_q      <= 1'b0;
			byp_done_q  <= 1'b0;
			cnt_q       <= '0;
			flag_miss_q <= 1'b0;
			flag_wb_q   <= 1'b0;
			flag_rand_q <= 1'b0;
		end else begin
			byp_done_q  <= 1'b0; // pulses
			flag_miss_q <= 1'b0;
			flag_wb_q   <= 1'b0;
			flag_rand_q <= 1'b0;
			case (state_q)
				ST_IDLE: if (core_req_i) begin
					state_q <= ST_LOOKUP;
					retry_q <= 1'b0;
					miss_q  <= 1'b0;
				end
				ST_LOOKUP: begin
					if (sel_i.hit) begin
						state_q <= ST_HIT_READ;
					end else begin
						miss_q      <= 1'b1;
						flag_miss_q <= !retry_q;
						cnt_q       <= '0;
						if (lease_i == '0) begin
							state_q <= ST_BYP_REQ; // no caching
						end else begin
							flag_rand_q <= sel_i.forced;
							flag_wb_q   <= sel_i.victim_dirty;
							state_q     <= sel_i.victim_dirty ? ST_WRITEBACK : ST_FILL_REQ;
						end
					end
				end
				ST_HIT_READ: state_q <= ST_IDLE;
				ST_WRITEBACK: if (mem_ready_i) begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '1)
						state_q <= ST_FILL_REQ;
				end
				ST_FILL_REQ: if (mem_ready_i) begin
					state_q <= ST_FILL;
				end
				ST_FILL: if (mem_rvalid_i) begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == '1) begin
						state_q <= ST_LOOKUP; // retry lookup now hits
						retry_q <= 1'b1;
					end
				end
				ST_BYP_REQ: if (mem_ready_i) begin
					byp_done_q <= req_q.rw;   // store is done on acceptance
					state_q    <= req_q.rw ? ST_IDLE : ST_BYP_WAIT;
				end
				ST_BYP_WAIT: if (mem_rvalid_i) begin
					byp_done_q <= 1'b1;
					state_q    <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// request and miss context
	always_ff @(posedge clock_i) begin
		if (state_q == ST_IDLE && core_req_i) begin
			req_q <= '{rw: core_rw_i, tag: core_addr_i[BW_ADDR-1:BW_BLOCK],
				word: core_addr_i[BW_BLOCK-1:0], data: core_wdata_i};
		end
		if (first_miss) begin
			victim_q     <= sel_i.victim_line;
			victim_tag_q <= sel_i.victim_tag;
			lease_q      <= lease_i;
		end
		if (state_q == ST_BYP_WAIT && mem_rvalid_i)
			byp_data_q <= mem_rdata_i;
	end

	// commands to lines and memories
	// ------------------------------
	always_comb begin
		line_cmd_o   = '0;
		evict_step_o = 1'b0;
		dm_we_o      = 1'b0;
		dm_waddr_o   = {sel_i.hit_line, req_q.word};
		dm_wdata_o   = req_q.data;
		dm_raddr_o   = {sel_i.hit_line, req_q.word};
		mem_cmd_o    = '0;
		case (state_q)
			ST_LOOKUP: begin
				line_cmd_o.age = !retry_q; // once per request
				if (sel_i.hit) begin
					line_cmd_o.renew     = 1'b1;
					line_cmd_o.target    = sel_i.hit_line;
					line_cmd_o.lease     = lease_i;
					line_cmd_o.set_dirty = req_q.rw;
					dm_we_o              = req_q.rw;
				end else if (first_miss) begin
					dm_raddr_o   = {sel_i.victim_line, {BW_BLOCK{1'b0}}}; // prefetch word 0
					evict_step_o = sel_i.forced;
				end
			end
			ST_WRITEBACK: begin
				mem_cmd_o.req   = mem_ready_i;
				mem_cmd_o.rw    = 1'b1;
				mem_cmd_o.addr  = {victim_tag_q, cnt_q};
				mem_cmd_o.wdata = rdata_i;
				dm_raddr_o      = {victim_q, wb_word};
				line_cmd_o.target = victim_q;
				line_cmd_o.clean  = mem_ready_i && (cnt_q == '1);
			end
			ST_FILL_REQ: begin
				mem_cmd_o.req   = mem_ready_i;
				mem_cmd_o.block = 1'b1;
				mem_cmd_o.addr  = {req_q.tag, {BW_BLOCK{1'b0}}};
			end
			ST_FILL: begin
				dm_we_o    = mem_rvalid_i;
				dm_waddr_o = {victim_q, cnt_q};
				dm_wdata_o = mem_rdata_i;
				if (mem_rvalid_i && cnt_q == '1) begin
					line_cmd_o.fill   = 1'b1; // last word in
					line_cmd_o.renew  = 1'b1;
					line_cmd_o.target = victim_q;
					line_cmd_o.tag    = req_q.tag;
					line_cmd_o.lease  = lease_q;
				end
			end
			ST_BYP_REQ: begin
				mem_cmd_o.req   = mem_ready_i;
				mem_cmd_o.rw    = req_q.rw;
				mem_cmd_o.addr  = {req_q.tag, req_q.word};
				mem_cmd_o.wdata = req_q.data;
			end
			default: ;
		endcase
	end

	// strobe only on a ready bus with no read data still due
	a_req_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_cmd_o.req |-> mem_ready_i && !mem_rvalid_i);

endmodule

//--- design/lease_cache_top.sv
`timescale 1ns/1ns

module lease_cache_top (
	input  logic                                 clock_i,
	input  logic                                 resetn_i,
	// core
	input  logic                                 core_req_i,
	input  logic                                 core_rw_i,
	input  logic [lease_cache_pkg::BW_ADDR-1:0]  core_addr_i,
	input  logic [lease_cache_pkg::BW_DATA-1:0]  core_wdata_i,
	output logic                                 core_done_o,
	output logic                                 core_hit_o,
	output logic [lease_cache_pkg::BW_DATA-1:0]  core_rdata_o,
	// memory
	output lease_cache_pkg::mem_cmd_t            mem_cmd_o,
	input  logic                                 mem_ready_i,
	input  logic                                 mem_rvalid_i,
	input  logic [lease_cache_pkg::BW_DATA-1:0]  mem_rdata_i,
	// lease table programming
	input  logic                                 llt_wren_i,
	input  logic [lease_cache_pkg::BW_LLT-1:0]   llt_idx_i,
	input  logic [lease_cache_pkg::BW_TAG-1:0]   llt_tag_i,
	input  logic [lease_cache_pkg::BW_LEASE-1:0] llt_lease_i,
	// performance
	output logic                                 flag_miss_o,
	output logic                                 flag_writeback_o,
	output logic                                 flag_rand_evict_o
);
	import lease_cache_pkg::*;

	core_req_t           req;
	logic [BW_LEASE-1:0] lease;
	line_sel_t           sel;
	line_cmd_t           line_cmd;
	line_status_t        status [N_LINES];
	logic                evict_step;
	logic                dm_we;
	logic [BW_DMEM-1:0]  dm_waddr;
	logic [BW_DATA-1:0]  dm_wdata;
	logic [BW_DMEM-1:0]  dm_raddr;
	logic [BW_DATA-1:0]  dm_rdata;

	lease_table u_llt (
		.clock_i, .resetn_i, .llt_wren_i, .llt_idx_i, .llt_tag_i, .llt_lease_i,
		.search_tag_i (req.tag),
		.lease_o      (lease)
	);

	lease_cache_ctrl u_ctrl (
		.clock_i, .resetn_i, .core_req_i, .core_rw_i, .core_addr_i, .core_wdata_i,
		.core_done_o, .core_hit_o, .core_rdata_o,
		.lease_i (lease), .req_o (req), .sel_i (sel), .line_cmd_o (line_cmd),
		.evict_step_o (evict_step),
		.dm_we_o (dm_we), .dm_waddr_o (dm_waddr), .dm_wdata_o (dm_wdata),
		.dm_raddr_o (dm_raddr), .rdata_i (dm_rdata),
		.mem_cmd_o, .mem_ready_i, .mem_rvalid_i, .mem_rdata_i,
		.flag_miss_o, .flag_writeback_o, .flag_rand_evict_o
	);

	// one lease_line per cache line
	for (genvar i = 0; i < N_LINES; i++) begin : g_line
		lease_line #(.LINE_INDEX(i)) u_line (
			.clock_i, .resetn_i,
			.cmd_i       (line_cmd),
			.probe_tag_i (req.tag),
			.status_o    (status[i])
		);
	end

	line_select u_sel (
		.clock_i, .resetn_i,
		.status_i     (status),
		.evict_step_i (evict_step),
		.sel_o        (sel)
	);

	cache_data_mem u_dmem (
		.clock_i,
		.we_i (dm_we), .waddr_i (dm_waddr), .wdata_i (dm_wdata),
		.raddr_i (dm_raddr), .rdata_o (dm_rdata)
	);

endmodule

//--- verif/lease_cache_tb.sv
`timescale 1ns/1ns

module lease_cache_tb;
	import lease_cache_pkg::*;

	localparam int          TIMEOUT_CYCLES = 4000;          // ~35 accesses under 30 cycles each
	localparam logic [31:0] DATA_OFS       = 32'h0BAD_0000; // unwritten word = addr + offset

	logic                clock_i = 1'b0;
	logic                resetn_i;
	logic                core_req_i, core_rw_i;
	logic [BW_ADDR-1:0]  core_addr_i;
	logic [BW_DATA-1:0]  core_wdata_i, core_rdata_o;
	logic                core_done_o, core_hit_o;
	mem_cmd_t            mem_cmd_o;
	logic                mem_ready_i, mem_rvalid_i;
	logic [BW_DATA-1:0]  mem_rdata_i;
	logic                llt_wren_i;
	logic [BW_LLT-1:0]   llt_idx_i;
	logic [BW_TAG-1:0]   llt_tag_i;
	logic [BW_LEASE-1:0] llt_lease_i;
	logic                flag_miss_o, flag_writeback_o, flag_rand_evict_o;

	// memory model state
	logic [31:0]         wr_mem [int];    // written words only
	logic [BW_ADDR-1:0]  wlog_addr [$];   // write log in arrival order
	logic [31:0]         wlog_data [$];
	logic [31:0]         rsp_q [$];       // read words waiting for rvalid
	logic [31:0]         lcg_state = 32'd78;
	logic [31:0]         rnd;

	int cycle_cnt = 0;
	int n_checks = 0, n_errors = 0, test_errors = 0;
	int miss_cnt = 0, wb_cnt = 0, rand_cnt = 0; // flag pulse counts

	lease_cache_top uut (.*);

	always #10 clock_i = ~clock_i;

	// model and watchdog
	// ------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [31:0] mem_word(input logic [BW_ADDR-1:0] addr);
		if (wr_mem.exists(int'(addr)))
			return wr_mem[int'(addr)];
		return DATA_OFS + 32'(addr);
	endfunction

	// commands are stable mid-cycle and taken at the next edge
	always @(negedge clock_i) begin
		if (resetn_i && mem_cmd_o.req) begin
			if (mem_cmd_o.rw) begin
				wr_mem[int'(mem_cmd_o.addr)] = mem_cmd_o.wdata;
				wlog_addr.push_back(mem_cmd_o.addr);
				wlog_data.push_back(mem_cmd_o.wdata);
			end else if (mem_cmd_o.block) begin
				for (int w = 0; w < 4; w++)
					rsp_q.push_back(mem_word(mem_cmd_o.addr + BW_ADDR'(w))); // word order
			end else begin
				rsp_q.push_back(mem_word(mem_cmd_o.addr));
			end
		end
		if (resetn_i) begin
			miss_cnt += flag_miss_o;
			wb_cnt   += flag_writeback_o;
			rand_cnt += flag_rand_evict_o;
		end
	end

	// ready and rvalid both gated by the lcg
	always @(posedge clock_i) begin
		#2;
		rnd = lcg_next();
		mem_ready_i = (rnd[31:30] != 2'b00); // ready about 3 of 4 cycles
		if (rsp_q.size() > 0 && rnd[29:28] != 2'b00) begin
			mem_rvalid_i = 1'b1;
			mem_rdata_i  = rsp_q.pop_front();
		end else begin
			mem_rvalid_i = 1'b0;
			mem_rdata_i  = '0;
		end
	end

	always @(posedge clock_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// helpers
	// ------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			n_errors++;
			test_errors++;
		end
	endtask

	task automatic reset_dut();
		@(posedge clock_i);
		#2 resetn_i = 1'b0;
		repeat (8) @(posedge clock_i);
		#2 resetn_i = 1'b1;
		@(negedge clock_i);
		check("core_done_o", 32'(core_done_o), 0);
		check("mem_cmd_o.req", 32'(mem_cmd_o.req), 0);
		check("flags", {29'd0, flag_miss_o, flag_writeback_o, flag_rand_evict_o}, 0);
	endtask

	task automatic program_lease(input int idx, input int tag, input logic [7:0] lease);
		@(posedge clock_i);
		#2;
		llt_wren_i  = 1'b1;
		llt_idx_i   = BW_LLT'(idx);
		llt_tag_i   = BW_TAG'(tag);
		llt_lease_i = lease;
		@(posedge clock_i);
		#2 llt_wren_i = 1'b0;
	endtask

	// cycles counts edges from the request to done
	task automatic access(input logic rw, input logic [BW_ADDR-1:0] addr,
		input logic [31:0] wdata, output logic hit, output logic [31:0] rdata, output int cycles);
		logic got;
		@(posedge clock_i);
		#2;
		core_req_i   = 1'b1;
		core_rw_i    = rw;
		core_addr_i  = addr;
		core_wdata_i = wdata;
		cycles = 0;
		got    = 1'b0;
		while (!got) begin
			@(posedge clock_i);
			cycles++;
			#2 core_req_i = 1'b0; // one-cycle strobe
			@(negedge clock_i);
			got   = core_done_o;
			hit   = core_hit_o;
			rdata = core_rdata_o;
		end
	endtask

	task automatic read_expect(input logic [BW_ADDR-1:0] addr, input logic [31:0] exp,
		input logic exp_hit);
		logic        hit;
		logic [31:0] rdata;
		int          cycles;
		access(1'b0, addr, '0, hit, rdata, cycles);
		check("core_hit_o", 32'(hit), 32'(exp_hit));
		check("core_rdata_o", rdata, exp);
		if (exp_hit)
			check("hit latency", cycles, 2);
	endtask

	task automatic write_expect(input logic [BW_ADDR-1:0] addr, input logic [31:0] data,
		input logic exp_hit);
		logic        hit;
		logic [31:0] rdata;
		int          cycles;
		access(1'b1, addr, data, hit, rdata, cycles);
		check("core_hit_o", 32'(hit), 32'(exp_hit));
	endtask

	task automatic finish_test(input string name);
		$display("%-18s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	// directed tests
	// ------------------------------
	task automatic read_miss_then_hit();
		int miss0;
		miss0 = miss_cnt;
		read_expect(12'h040, DATA_OFS + 32'h040, 1'b0); // fills line 0
		check("flag_miss_o pulses", miss_cnt - miss0, 1);
		read_expect(12'h041, DATA_OFS + 32'h041, 1'b1);
		check("flag_miss_o pulses", miss_cnt - miss0, 1);
		finish_test("read_miss_then_hit");
	endtask

	task automatic dirty_writeback();
		int wb0, rr0, n0;
		wb0 = wb_cnt;
		rr0 = rand_cnt;
		read_expect(12'h044, DATA_OFS + 32'h044, 1'b0);
		write_expect(12'h046, 32'hDEAD_BEEF, 1'b1);    // line 0 now dirty
		read_expect(12'h046, 32'hDEAD_BEEF, 1'b1);
		for (int i = 0; i < 4; i++)  // lines 1..4 while line 0 counts down to 0
			read_expect(12'h080 + BW_ADDR'(4*i), DATA_OFS + 32'h080 + 32'(4*i), 1'b0);
		check("flag_writeback_o pulses", wb_cnt - wb0, 0);
		n0 = wlog_addr.size();
		read_expect(12'h090, DATA_OFS + 32'h090, 1'b0); // expired dirty line 0 goes
		check("flag_writeback_o pulses", wb_cnt - wb0, 1);
		check("writeback strobes", wlog_addr.size() - n0, 4);
		if (wlog_addr.size() - n0 == 4) begin
			for (int i = 0; i < 4; i++) begin
				check("writeback addr", 32'(wlog_addr[n0+i]), 32'h044 + 32'(i));
				check("writeback data", wlog_data[n0+i],
					(i == 2) ? 32'hDEAD_BEEF : DATA_OFS + 32'h044 + 32'(i));
			end
		end
		read_expect(12'h046, 32'hDEAD_BEEF, 1'b0); // refetched from memory
		check("flag_rand_evict_o pulses", rand_cnt - rr0, 0);
		finish_test("dirty_writeback");
	endtask

	task automatic zero_lease_bypass();
		int miss0, n0;
		program_lease(0, 10'h030, 8'd0);
		miss0 = miss_cnt;
		read_expect(12'h0C1, DATA_OFS + 32'h0C1, 1'b0);
		read_expect(12'h0C1, DATA_OFS + 32'h0C1, 1'b0); // still not cached
		check("flag_miss_o pulses", miss_cnt - miss0, 2);
		n0 = wlog_addr.size();
		write_expect(12'h0C2, 32'h1234_5678, 1'b0);
		check("bypass write strobes", wlog_addr.size() - n0, 1);
		if (wlog_addr.size() - n0 == 1) begin
			check("bypass write addr", 32'(wlog_addr[n0]), 32'h0C2);
			check("bypass write data", wlog_data[n0], 32'h1234_5678);
		end
		read_expect(12'h0C2, 32'h1234_5678, 1'b0);
		finish_test("zero_lease_bypass");
	endtask

	task automatic lease_expiry();
		int rr0;
		program_lease(0, 10'h040, 8'd1);
		rr0 = rand_cnt;
		read_expect(12'h100, DATA_OFS + 32'h100, 1'b0); // line 0 with lease 1
		read_expect(12'h104, DATA_OFS + 32'h104, 1'b0); // line 1 while line 0 expires
		read_expect(12'h105, DATA_OFS + 32'h105, 1'b1);
		read_expect(12'h108, DATA_OFS + 32'h108, 1'b0); // takes expired line 0
		read_expect(12'h100, DATA_OFS + 32'h100, 1'b0); // so this one is gone
		read_expect(12'h104, DATA_OFS + 32'h104, 1'b1);
		read_expect(12'h108, DATA_OFS + 32'h108, 1'b1);
		check("flag_rand_evict_o pulses", rand_cnt - rr0, 0);
		finish_test("lease_expiry");
	endtask

	task automatic round_robin_evict();
		int rr0, wb0;
		for (int i = 0; i < 8; i++)
			program_lease(i, 10'h050 + i, 8'd200);
		for (int i = 0; i < 8; i++)  // line i gets tag 0x50+i
			read_expect(12'h140 + BW_ADDR'(4*i), DATA_OFS + 32'h140 + 32'(4*i), 1'b0);
		rr0 = rand_cnt;
		wb0 = wb_cnt;
		read_expect(12'h180, DATA_OFS + 32'h180, 1'b0); // no free line and pointer at 0
		check("flag_rand_evict_o pulses", rand_cnt - rr0, 1);
		read_expect(12'h140, DATA_OFS + 32'h140, 1'b0); // evicted tag misses
		check("flag_rand_evict_o pulses", rand_cnt - rr0, 2);
		read_expect(12'h148, DATA_OFS + 32'h148, 1'b1);
		read_expect(12'h14C, DATA_OFS + 32'h14C, 1'b1);
		read_expect(12'h150, DATA_OFS + 32'h150, 1'b1);
		// default lease of 4 on line 0 is used up by now
		read_expect(12'h184, DATA_OFS + 32'h184, 1'b0);
		check("flag_rand_evict_o pulses", rand_cnt - rr0, 2);
		read_expect(12'h180, DATA_OFS + 32'h180, 1'b0);
		check("flag_writeback_o pulses", wb_cnt - wb0, 0);
		finish_test("round_robin_evict");
	endtask

	// main sequence
	// ------------------------------
	initial begin
		resetn_i     = 1'b0;
		core_req_i   = 1'b0;
		core_rw_i    = 1'b0;
		core_addr_i  = '0;
		core_wdata_i = '0;
		mem_ready_i  = 1'b0;
		mem_rvalid_i = 1'b0;
		mem_rdata_i  = '0;
		llt_wren_i   = 1'b0;
		llt_idx_i    = '0;
		llt_tag_i    = '0;
		llt_lease_i  = '0;
		reset_dut();
		read_miss_then_hit();
		reset_dut();
		dirty_writeback();
		reset_dut();
		zero_lease_bypass();
		reset_dut();
		lease_expiry();
		reset_dut();
		round_robin_evict();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- vlog.f
design/lease_cache_pkg.sv
design/lease_table.sv
design/lease_line.sv
design/line_select.sv
design/cache_data_mem.sv
design/lease_cache_ctrl.sv
design/lease_cache_top.sv
verif/lease_cache_tb.sv
